// ==== verilog/arb_defs.svh ====
`ifndef ARB_DEFS_SVH
`define ARB_DEFS_SVH

// Router geometry

`define ARB_PORTS 5 // N, S, W, E, L
`define COORD_W   4 // One mesh coordinate
`define SEL_W     3 // Port index / crossbar select

`endif

// ==== verilog/noc_pkg.sv ====
`default_nettype none

`include "arb_defs.svh"

package noc_pkg;

	// Router port indices, also used as crossbar selects
	typedef enum logic [`SEL_W-1:0] {
		PORT_N = 3'd0,
		PORT_S = 3'd1,
		PORT_W = 3'd2,
		PORT_E = 3'd3,
		PORT_L = 3'd4
	} port_e;

	typedef logic [`COORD_W-1:0] coord_t;

	// Header address, y in the upper nibble
	typedef struct packed {
		coord_t y;
		coord_t x;
	} node_addr_t;

endpackage

`default_nettype wire

// ==== verilog/arb_pkg.sv ====
`default_nettype none

`include "arb_defs.svh"

package arb_pkg;

	// One bit per router port
	typedef logic [`ARB_PORTS-1:0] port_vec_t;

	// Binary crossbar select, names the granted input
	typedef noc_pkg::port_e xsel_t;

endpackage

`default_nettype wire

// ==== verilog/route_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

interface route_if;
	import noc_pkg::*;
	import arb_pkg::*;

	port_vec_t route_valid;             // Pending or granted route per input
	port_e     route_port [`ARB_PORTS]; // Next hop per input

	// Indexed [output][input]
	port_vec_t grant [`ARB_PORTS];
	port_vec_t done  [`ARB_PORTS];      // One-cycle release pulses

	modport stage (
		output route_valid,
		output route_port,
		input  done
	);

	modport arbiter (
		input  route_valid,
		input  route_port,
		output grant,
		output done
	);

	modport encoder (
		input grant
	);

	modport monitor (
		input route_valid,
		input route_port,
		input grant,
		input done
	);

endinterface

`default_nettype wire

// ==== verilog/yx_route_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

module yx_route_stage (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  noc_pkg::node_addr_t  router_addr_i,
	input  noc_pkg::node_addr_t  hdr_addr_i [`ARB_PORTS],
	input  arb_pkg::port_vec_t   hdr_write_i,
	route_if.stage               rt
);
	import noc_pkg::*;
	import arb_pkg::*;

	port_vec_t valid_q;
	port_e     port_q    [`ARB_PORTS];
	port_e     next_port [`ARB_PORTS];
	port_vec_t accept;
	port_vec_t done_in;

	// Y is resolved before X
	function automatic port_e yx_route(input node_addr_t dst, input node_addr_t here);
		port_e p;
		if (dst.y > here.y) begin
			p = PORT_N;
		end else if (dst.y < here.y) begin
			p = PORT_S;
		end else if (dst.x > here.x) begin
			p = PORT_E;
		end else if (dst.x < here.x) begin
			p = PORT_W;
		end else begin
			p = PORT_L; // Packet has arrived
		end
		return p;
	endfunction

	always_comb begin
		for (int j = 0; j < `ARB_PORTS; j++) begin
			next_port[j] = yx_route(hdr_addr_i[j], router_addr_i);
		end
	end

	// An input is released when any output drops its grant
	always_comb begin
		done_in = '0;
		for (int o = 0; o < `ARB_PORTS; o++) begin
			done_in |= rt.done[o];
		end
	end

	assign accept = hdr_write_i & ~valid_q; // Busy inputs ignore writes

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= '0;
		end else begin
			for (int j = 0; j < `ARB_PORTS; j++) begin
				if (done_in[j]) begin
					valid_q[j] <= 1'b0;
				end else if (accept[j]) begin
					valid_q[j] <= 1'b1;
				end
			end
		end
	end

	// Next-hop register
	always_ff @(posedge clk) begin
		for (int j = 0; j < `ARB_PORTS; j++) begin
			if (accept[j]) begin
				port_q[j] <= next_port[j];
			end
		end
	end

	assign rt.route_valid = valid_q;
	assign rt.route_port  = port_q;

endmodule

`default_nettype wire

// ==== verilog/rr_output_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

module rr_output_arbiter #(
	parameter noc_pkg::port_e OUT_PORT = noc_pkg::PORT_L
) (
	input  logic       clk,
	input  logic       rst_n_i,
	input  logic       release_i,
	route_if.arbiter   rt
);
	import noc_pkg::*;
	import arb_pkg::*;

	port_vec_t req;
	port_vec_t req_live;
	port_e     winner;
	port_vec_t grant_q;
	port_vec_t done_q;
	port_e     ptr_q;   // Last winner
	logic      busy;

	// Requests for this output, U-turns excluded
	always_comb begin
		req = '0;
		for (int j = 0; j < `ARB_PORTS; j++) begin
			if (rt.route_valid[j] && (rt.route_port[j] == OUT_PORT) && (j != int'(OUT_PORT))) begin
				req[j] = 1'b1;
			end
		end
	end

	// The input just released still shows valid for one cycle
	assign req_live = req & ~done_q;

	// First requester after the last winner, cyclic
	function automatic port_e rr_pick(input port_vec_t r, input port_e last);
		int unsigned idx;
		port_e       win;
		win = last;
		for (int k = `ARB_PORTS; k >= 1; k--) begin
			idx = (int'(last) + k) % `ARB_PORTS;
			if (r[idx]) begin
				win = port_e'(idx);
			end
		end
		return win;
	endfunction

	assign winner = rr_pick(req_live, ptr_q);
	assign busy   = |grant_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			grant_q <= '0;
			done_q  <= '0;
			ptr_q   <= PORT_L; // First search starts at N
		end else begin
			done_q <= '0;
			if (busy) begin
				if (release_i) begin
					grant_q <= '0;
					done_q  <= grant_q;
				end
			end else if (|req_live) begin
				grant_q <= port_vec_t'(1) << winner;
				ptr_q   <= winner;
			end
		end
	end

	assign rt.grant[OUT_PORT] = grant_q;
	assign rt.done[OUT_PORT]  = done_q;

endmodule

`default_nettype wire

// ==== verilog/xbar_select_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

module xbar_select_encoder (
	input  logic                clk,
	input  logic                rst_n_i,
	route_if.encoder            rt,
	output arb_pkg::port_vec_t  xsel_valid_o,
	output arb_pkg::xsel_t      xsel_o [`ARB_PORTS],
	output arb_pkg::port_vec_t  in_granted_o
);
	import arb_pkg::*;

	port_vec_t granted_any;

	function automatic xsel_t onehot_to_sel(input port_vec_t oh);
		logic [`SEL_W-1:0] sel;
		sel = '0;
		for (int j = 0; j < `ARB_PORTS; j++) begin
			if (oh[j]) begin
				sel |= `SEL_W'(j);
			end
		end
		return xsel_t'(sel);
	endfunction

	// Inputs granted by any output
	always_comb begin
		granted_any = '0;
		for (int o = 0; o < `ARB_PORTS; o++) begin
			granted_any |= rt.grant[o];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			xsel_valid_o <= '0;
			in_granted_o <= '0;
		end else begin
			for (int o = 0; o < `ARB_PORTS; o++) begin
				xsel_valid_o[o] <= |rt.grant[o];
			end
			in_granted_o <= granted_any;
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < `ARB_PORTS; o++) begin
			xsel_o[o] <= onehot_to_sel(rt.grant[o]); // Only meaningful with valid
		end
	end

endmodule

`default_nettype wire

// ==== verilog/router_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

module router_arbiter (
	input  logic                 clk,
	input  logic                 rst_n_i,

	input  noc_pkg::node_addr_t  router_addr_i,

	// Header address and write strobe per input
	input  noc_pkg::node_addr_t  hdr_addr_i [`ARB_PORTS],
	input  arb_pkg::port_vec_t   hdr_write_i,

	input  arb_pkg::port_vec_t   release_i,    // Per output

	output arb_pkg::port_vec_t   xsel_valid_o, // Per output
	output arb_pkg::xsel_t       xsel_o [`ARB_PORTS],
	output arb_pkg::port_vec_t   in_granted_o  // Per input
);
	import noc_pkg::*;

	route_if rt_if ();

	yx_route_stage route_stage_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.router_addr_i (router_addr_i),
		.hdr_addr_i    (hdr_addr_i),
		.hdr_write_i   (hdr_write_i),
		.rt            (rt_if.stage)
	);

	// One arbiter per output port
	for (genvar o = 0; o < `ARB_PORTS; o++) begin : gen_arb
		rr_output_arbiter #(
			.OUT_PORT (port_e'(o))
		) arb_i (
			.clk       (clk),
			.rst_n_i   (rst_n_i),
			.release_i (release_i[o]),
			.rt        (rt_if.arbiter)
		);
	end

	xbar_select_encoder encoder_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.rt           (rt_if.encoder),
		.xsel_valid_o (xsel_valid_o),
		.xsel_o       (xsel_o),
		.in_granted_o (in_granted_o)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS = 8.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2.0) clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/router_arbiter_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

module router_arbiter_checker (
	input  logic      clk_i,
	input  logic      rst_n_i,
	route_if.monitor  rt
);
	import arb_pkg::*;

	port_vec_t grant_col [`ARB_PORTS]; // Indexed [input][output]

	always_comb begin
		for (int j = 0; j < `ARB_PORTS; j++) begin
			for (int o = 0; o < `ARB_PORTS; o++) begin
				grant_col[j][o] = rt.grant[o][j];
			end
		end
	end

	for (genvar o = 0; o < `ARB_PORTS; o++) begin : gen_out
		a_row_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			$onehot0(rt.grant[o]))
			else $error("Output %0d grants more than one input", o);

		a_no_uturn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			!rt.grant[o][o])
			else $error("Output %0d granted to its own input", o);

		// Release pulse
		a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			(rt.done[o] != '0) |=> (rt.done[o] == '0))
			else $error("Done of output %0d held longer than one cycle", o);
	end

	for (genvar j = 0; j < `ARB_PORTS; j++) begin : gen_in
		a_single_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			$onehot0(grant_col[j]))
			else $error("Input %0d granted by two outputs", j);
	end

endmodule

`default_nettype wire

// ==== testbench/router_arbiter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "arb_defs.svh"

module router_arbiter_tb;
	import noc_pkg::*;
	import arb_pkg::*;

	localparam int MAX_CYCLES = 4000;

	logic       clk;
	logic       rst_n;
	node_addr_t router_addr;
	node_addr_t hdr_addr [`ARB_PORTS];
	port_vec_t  hdr_write;
	port_vec_t  rel_strobe;
	port_vec_t  xsel_valid;
	port_vec_t  in_granted;
	xsel_t      xsel [`ARB_PORTS];
	integer     seed;
	int         cycles = 0;

	// Reference model state
	port_vec_t  m_valid;
	port_e      m_port [`ARB_PORTS];
	port_vec_t  m_grant [`ARB_PORTS];
	port_vec_t  m_done [`ARB_PORTS];
	int         m_ptr [`ARB_PORTS];
	port_vec_t  m_xvalid;
	port_vec_t  m_ingr;
	xsel_t      m_xsel [`ARB_PORTS];

	tb_clock_gen clk_gen_i (.clk_o(clk));

	router_arbiter dut_i (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.router_addr_i (router_addr),
		.hdr_addr_i    (hdr_addr),
		.hdr_write_i   (hdr_write),
		.release_i     (rel_strobe),
		.xsel_valid_o  (xsel_valid),
		.xsel_o        (xsel),
		.in_granted_o  (in_granted)
	);

	bind router_arbiter router_arbiter_checker checker_i (
		.clk_i   (clk),
		.rst_n_i (rst_n_i),
		.rt      (rt_if)
	);

	task automatic fail_now();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_vec(input string name, input port_vec_t got, input port_vec_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got=%h exp=%h", name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_xsel(input string name, input xsel_t got, input xsel_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got=%h exp=%h", name, got, exp);
			fail_now();
		end
	endtask

	// YX rule with Y resolved first
	function automatic port_e expected_hop(input node_addr_t a);
		if (a.y != router_addr.y) begin
			return (a.y > router_addr.y) ? PORT_N : PORT_S;
		end
		if (a.x != router_addr.x) begin
			return (a.x > router_addr.x) ? PORT_E : PORT_W;
		end
		return PORT_L;
	endfunction

	function automatic node_addr_t addr_toward(input port_e p);
		node_addr_t a;
		a = router_addr;
		case (p)
			PORT_N:  a.y = a.y + 4'd1;
			PORT_S:  a.y = a.y - 4'd1;
			PORT_E:  a.x = a.x + 4'd1;
			PORT_W:  a.x = a.x - 4'd1;
			default: a = router_addr;
		endcase
		return a;
	endfunction

	task automatic clear_model();
		m_valid  = '0;
		m_xvalid = '0;
		m_ingr   = '0;
		for (int o = 0; o < `ARB_PORTS; o++) begin
			m_grant[o] = '0;
			m_done[o]  = '0;
			m_ptr[o]   = int'(PORT_L); // Search starts at N
		end
	endtask

	// Model of one clock edge with every block reading the old state
	task automatic step_model();
		port_vec_t released;
		port_vec_t req;
		int        idx;
		released = '0;
		m_ingr   = '0;
		for (int o = 0; o < `ARB_PORTS; o++) begin
			released |= m_done[o];
			m_ingr   |= m_grant[o];
			m_xvalid[o] = |m_grant[o];
			for (int j = 0; j < `ARB_PORTS; j++) begin
				if (m_grant[o][j]) begin
					m_xsel[o] = xsel_t'(j);
				end
			end
		end
		for (int o = 0; o < `ARB_PORTS; o++) begin
			req = '0;
			for (int j = 0; j < `ARB_PORTS; j++) begin
				if (m_valid[j] && m_port[j] == port_e'(o) && j != o && !m_done[o][j]) begin
					req[j] = 1'b1;
				end
			end
			if (m_grant[o] != '0) begin
				m_done[o] = rel_strobe[o] ? m_grant[o] : '0;
				if (rel_strobe[o]) begin
					m_grant[o] = '0;
				end
			end else begin
				m_done[o] = '0;
				for (int k = 1; k <= `ARB_PORTS && m_grant[o] == '0; k++) begin
					idx = (m_ptr[o] + k) % `ARB_PORTS;
					if (req[idx]) begin
						m_grant[o] = port_vec_t'(1) << idx;
						m_ptr[o]   = idx;
					end
				end
			end
		end
		for (int j = 0; j < `ARB_PORTS; j++) begin
			if (released[j]) begin
				m_valid[j] = 1'b0;
			end else if (hdr_write[j] && !m_valid[j]) begin
				m_valid[j] = 1'b1;
				m_port[j]  = expected_hop(hdr_addr[j]);
			end
		end
	endtask

	task automatic compare_outputs();
		check_vec("xsel_valid_o", xsel_valid, m_xvalid);
		check_vec("in_granted_o", in_granted, m_ingr);
		for (int o = 0; o < `ARB_PORTS; o++) begin
			if (m_xvalid[o]) begin
				check_xsel($sformatf("xsel_o[%0d]", o), xsel[o], m_xsel[o]);
			end
		end
	endtask

	// Advances the model and compares the outputs on each edge
	task automatic wait_edges(input int n);
		repeat (n) begin
			@(posedge clk);
			if (!rst_n) begin
				clear_model();
			end else begin
				step_model();
			end
			#1;
			if (rst_n) begin
				compare_outputs();
			end
		end
	endtask

	task automatic reset_dut();
		rst_n      = 1'b0;
		hdr_write  = '0;
		rel_strobe = '0;
		wait_edges(10);
		rst_n = 1'b1;
	endtask

	task automatic write_headers(input port_vec_t mask, input node_addr_t a);
		for (int j = 0; j < `ARB_PORTS; j++) begin
			if (mask[j]) begin
				hdr_addr[j] = a;
			end
		end
		hdr_write = mask;
		wait_edges(1);
		hdr_write = '0;
	endtask

	task automatic release_output(input port_e o);
		rel_strobe = port_vec_t'(1) << o;
		wait_edges(1);
		rel_strobe = '0;
	endtask

	task automatic route_each_direction();
		port_e dest;
		reset_dut();
		for (int j = 0; j < `ARB_PORTS; j++) begin
			for (int o = 0; o < `ARB_PORTS; o++) begin
				if (o != j) begin
					dest = port_e'(o);
					write_headers(port_vec_t'(1) << j, addr_toward(dest));
					wait_edges(2);
					check_vec("xsel_valid_o", xsel_valid, port_vec_t'(1) << o);
					check_xsel("xsel_o", xsel[o], xsel_t'(j));
					check_vec("in_granted_o", in_granted, port_vec_t'(1) << j);
					release_output(dest);
					wait_edges(1);
					check_vec("in_granted_o", in_granted, '0);
				end
			end
		end
		// A U-turn request from L is never granted
		write_headers(port_vec_t'(1) << PORT_L, addr_toward(PORT_L));
		wait_edges(4);
		check_vec("xsel_valid_o", xsel_valid, '0);
	endtask

	task automatic rotate_grants_on_l();
		reset_dut();
		write_headers(~(port_vec_t'(1) << PORT_L), addr_toward(PORT_L));
		wait_edges(2);
		for (int i = 0; i < 4; i++) begin
			check_xsel("xsel_o[L]", xsel[PORT_L], xsel_t'(i)); // N, S, W, E
			check_vec("in_granted_o", in_granted, port_vec_t'(1) << i);
			release_output(PORT_L);
			wait_edges(2);
		end
		check_vec("xsel_valid_o", xsel_valid, '0);
	endtask

	task automatic hold_grant_until_release();
		reset_dut();
		write_headers((port_vec_t'(1) << PORT_W) | (port_vec_t'(1) << PORT_L),
			addr_toward(PORT_E));
		wait_edges(2);
		for (int i = 0; i < 20; i++) begin
			check_xsel("xsel_o[E]", xsel[PORT_E], PORT_W);
			check_vec("in_granted_o", in_granted, port_vec_t'(1) << PORT_W);
			wait_edges(1);
		end
		release_output(PORT_E);
		wait_edges(1);
		check_vec("in_granted_o", in_granted, '0);
		wait_edges(1);
		check_xsel("xsel_o[E]", xsel[PORT_E], PORT_L);
		check_vec("in_granted_o", in_granted, port_vec_t'(1) << PORT_L);
		release_output(PORT_E);
		wait_edges(2);
	endtask

	task automatic ignore_busy_writes();
		port_vec_t pair;
		pair = (port_vec_t'(1) << PORT_N) | (port_vec_t'(1) << PORT_E);
		reset_dut();
		write_headers(pair, addr_toward(PORT_W));
		wait_edges(2);
		write_headers(pair, addr_toward(PORT_S)); // N is granted and E still pending
		wait_edges(2);
		check_vec("xsel_valid_o", xsel_valid, port_vec_t'(1) << PORT_W);
		check_xsel("xsel_o[W]", xsel[PORT_W], PORT_N);
		release_output(PORT_W);
		wait_edges(2);
		check_vec("xsel_valid_o", xsel_valid, port_vec_t'(1) << PORT_W);
		check_xsel("xsel_o[W]", xsel[PORT_W], PORT_E);
		release_output(PORT_W);
		wait_edges(2);
	endtask

	task automatic run_random_traffic();
		logic [31:0] r;
		node_addr_t  a;
		reset_dut();
		for (int c = 0; c < 300; c++) begin
			for (int j = 0; j < `ARB_PORTS; j++) begin
				r   = $random(seed);
				a.y = router_addr.y + coord_t'(r[1:0]) - 4'd1; // Neighbourhood of the router
				a.x = router_addr.x + coord_t'(r[3:2]) - 4'd1;
				hdr_addr[j]  = a;
				hdr_write[j] = r[8] && (expected_hop(a) != port_e'(j));
			end
			r = $random(seed);
			rel_strobe = r[4:0] & r[9:5];
			wait_edges(1);
		end
		hdr_write  = '0;
		rel_strobe = '0;
		wait_edges(2);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Simulation timed out after %0d cycles", cycles);
			fail_now();
		end
	end

	initial begin
		seed        = 32'h6526ebc4;
		rst_n       = 1'b0;
		router_addr = 8'h55;
		hdr_write   = '0;
		rel_strobe  = '0;
		for (int j = 0; j < `ARB_PORTS; j++) begin
			hdr_addr[j] = '0;
		end
		route_each_direction();
		rotate_grants_on_l();
		hold_grant_until_release();
		ignore_busy_writes();
		run_random_traffic();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/noc_pkg.sv
verilog/arb_pkg.sv
verilog/route_if.sv
verilog/yx_route_stage.sv
verilog/rr_output_arbiter.sv
verilog/xbar_select_encoder.sv
verilog/router_arbiter.sv
testbench/tb_clock_gen.sv
testbench/router_arbiter_checker.sv
testbench/router_arbiter_tb.sv

// ==== Makefile ====
# Verilator simulation of the router arbiter

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module router_arbiter_tb -Mdir obj_dir
	./obj_dir/Vrouter_arbiter_tb | tee sim.log
	grep -q '^=== PASS ===$$' sim.log

clean:
	rm -rf obj_dir sim.log
